/* host_link_pkg.sv */
package host_link_pkg;

  // link frame geometry
  localparam int FRAME_BITS = 17;  // start bit + command + argument
  localparam int BYTE_BITS  = 8;
  localparam int WORD_BITS  = 16;
  localparam int ADDR_BITS  = 24;

  typedef logic [BYTE_BITS-1:0] byte_t;  // command, argument, reply byte
  typedef logic [WORD_BITS-1:0] word_t;  // memory data word
  typedef logic [ADDR_BITS-1:0] mem_addr_t;  // addr2:addr1:addr0

  // received frame, rx to exec
  typedef struct packed {
    byte_t cmd;
    byte_t arg;
  } link_frame_t;

  // reply frame, exec to tx; byte0 goes out first
  typedef struct packed {
    byte_t byte1;
    byte_t byte0;
  } reply_t;

  // command half of the memory port
  typedef struct packed {
    logic      write;  // 1 write, 0 read
    mem_addr_t addr;
    word_t     wdata;
  } mem_req_t;

  // parameter register loads
  localparam byte_t CMD_SET_DATA0 = 8'h10;
  localparam byte_t CMD_SET_DATA1 = 8'h11;
  localparam byte_t CMD_SET_ADDR0 = 8'h12;
  localparam byte_t CMD_SET_ADDR1 = 8'h13;
  localparam byte_t CMD_SET_ADDR2 = 8'h14;

  // link test
  localparam byte_t CMD_ECHO      = 8'h30;

  // single word memory access
  localparam byte_t CMD_MEM_WRITE = 8'hA0;
  localparam byte_t CMD_MEM_READ  = 8'hA1;

  localparam byte_t ECHO_TAG      = 8'h12;  // first byte of an echo reply

endpackage

/* link_rx.sv */
module link_rx #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                      sys_clk,
  input  logic                      sys_rst_n,
  input  logic                      link_in,
  input  logic                      link_strobe,
  output logic                      frame_valid,
  output host_link_pkg::link_frame_t frame
);

  localparam int PAYLOAD_BITS = host_link_pkg::FRAME_BITS - 1;  // cmd + arg
  localparam int BYTE_BITS    = host_link_pkg::BYTE_BITS;
  localparam int CNT_W        = $clog2(PAYLOAD_BITS);

  logic [SYNC_STAGES-1:0]  strobe_sync;
  logic [SYNC_STAGES-1:0]  data_sync;
  logic                    strobe_q;
  logic                    strobe_rise;
  logic                    data_bit;
  logic                    in_frame;  // start bit seen
  logic [CNT_W-1:0]        bit_cnt;
  logic [PAYLOAD_BITS-1:0] shreg;

  // same depth on both chains keeps data aligned with the strobe
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      strobe_sync <= '0;
      data_sync   <= '0;
      strobe_q    <= 1'b0;
    end else begin
      strobe_sync <= {strobe_sync[SYNC_STAGES-2:0], link_strobe};
      data_sync   <= {data_sync[SYNC_STAGES-2:0], link_in};
      strobe_q    <= strobe_sync[SYNC_STAGES-1];
    end
  end

  assign strobe_rise = strobe_sync[SYNC_STAGES-1] & ~strobe_q;
  assign data_bit    = data_sync[SYNC_STAGES-1];

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      in_frame    <= 1'b0;
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      if (strobe_rise) begin
        if (!in_frame) begin
          in_frame <= data_bit;  // wait for a 1 start bit
          bit_cnt  <= '0;
        end else if (bit_cnt == CNT_W'(PAYLOAD_BITS - 1)) begin
          in_frame    <= 1'b0;
          frame_valid <= 1'b1;  // 16th bit is in
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // lsb first, so the first bit ends up at bit 0
  always_ff @(posedge sys_clk) begin
    if (strobe_rise && in_frame) begin
      shreg <= {data_bit, shreg[PAYLOAD_BITS-1:1]};
    end
  end

  assign frame.cmd = shreg[BYTE_BITS-1:0];
  assign frame.arg = shreg[PAYLOAD_BITS-1:BYTE_BITS];

  // a frame is at least 16 strobe periods long, so the pulse stays single
  a_valid_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    frame_valid |=> !frame_valid);

endmodule

/* cmd_exec.sv */
module cmd_exec (
  input  logic                       sys_clk,
  input  logic                       sys_rst_n,
  input  logic                       frame_valid,
  input  host_link_pkg::link_frame_t frame,
  input  logic                       tx_busy,
  output logic                       reply_valid,
  output host_link_pkg::reply_t      reply,
  output logic                       mem_req,
  output host_link_pkg::mem_req_t    mem_cmd,
  input  logic                       mem_ack,
  input  host_link_pkg::word_t       mem_rdata,
  output logic                       busy
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EXEC,     // decode latched command
    ST_MEM_ACK,  // request up, waiting for ack
    ST_MEM_END,  // request down, waiting for ack to drop
    ST_REPLY     // reply held until tx is free
  } state_t;

  state_t                     state;
  host_link_pkg::link_frame_t frame_q;
  host_link_pkg::byte_t       data0;
  host_link_pkg::byte_t       data1;
  host_link_pkg::byte_t       addr0;
  host_link_pkg::byte_t       addr1;
  host_link_pkg::byte_t       addr2;

  assign busy = (state != ST_IDLE);

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state       <= ST_IDLE;
      reply_valid <= 1'b0;
      mem_req     <= 1'b0;
      data0       <= '0;
      data1       <= '0;
      addr0       <= '0;
      addr1       <= '0;
      addr2       <= '0;
    end else begin
      reply_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (frame_valid) begin
            state <= ST_EXEC;  // frames arriving while busy are dropped
          end
        end
        ST_EXEC: begin
          state <= ST_IDLE;
          case (frame_q.cmd)
            host_link_pkg::CMD_SET_DATA0: data0 <= frame_q.arg;
            host_link_pkg::CMD_SET_DATA1: data1 <= frame_q.arg;
            host_link_pkg::CMD_SET_ADDR0: addr0 <= frame_q.arg;
            host_link_pkg::CMD_SET_ADDR1: addr1 <= frame_q.arg;
            host_link_pkg::CMD_SET_ADDR2: addr2 <= frame_q.arg;
            host_link_pkg::CMD_ECHO: begin
              if (tx_busy) begin
                state <= ST_REPLY;
              end else begin
                reply_valid <= 1'b1;
              end
            end
            host_link_pkg::CMD_MEM_WRITE,
            host_link_pkg::CMD_MEM_READ: begin
              mem_req <= 1'b1;
              state   <= ST_MEM_ACK;
            end
            default: ;  // unknown code, no effect
          endcase
        end
        ST_MEM_ACK: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= ST_MEM_END;
          end
        end
        ST_MEM_END: begin
          if (!mem_ack) begin
            if (mem_cmd.write) begin
              state <= ST_IDLE;
            end else if (tx_busy) begin
              state <= ST_REPLY;
            end else begin
              reply_valid <= 1'b1;
              state       <= ST_IDLE;
            end
          end
        end
        ST_REPLY: begin
          if (!tx_busy) begin
            reply_valid <= 1'b1;
            state       <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // payload side
  always_ff @(posedge sys_clk) begin
    if (state == ST_IDLE && frame_valid) begin
      frame_q <= frame;
    end
    if (state == ST_EXEC) begin
      mem_cmd.write <= (frame_q.cmd == host_link_pkg::CMD_MEM_WRITE);
      mem_cmd.addr  <= {addr2, addr1, addr0};
      mem_cmd.wdata <= {data1, data0};
      reply.byte0   <= host_link_pkg::ECHO_TAG;
      reply.byte1   <= frame_q.arg;
    end
    if (state == ST_MEM_ACK && mem_ack) begin
      reply.byte0 <= mem_rdata[7:0];  // low byte goes first
      reply.byte1 <= mem_rdata[15:8];
    end
  end

  a_cmd_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    (mem_req && $past(mem_req)) |-> $stable(mem_cmd));

  // tx can only take a reply when idle
  a_reply_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    reply_valid |-> !tx_busy);

endmodule

/* link_tx.sv */
module link_tx #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  logic                  link_strobe,
  input  logic                  reply_valid,
  input  host_link_pkg::reply_t reply,
  output logic                  tx_busy,
  output logic                  link_out
);

  localparam int FRAME_BITS = host_link_pkg::FRAME_BITS;
  localparam int CNT_W      = $clog2(FRAME_BITS + 1);  // start, 16 data, stop 0

  logic [SYNC_STAGES-1:0] strobe_sync;
  logic                   strobe_q;
  logic                   strobe_rise;
  logic [CNT_W-1:0]       bit_cnt;
  logic [FRAME_BITS-1:0]  shreg;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      strobe_sync <= '0;
      strobe_q    <= 1'b0;
    end else begin
      strobe_sync <= {strobe_sync[SYNC_STAGES-2:0], link_strobe};
      strobe_q    <= strobe_sync[SYNC_STAGES-1];
    end
  end

  assign strobe_rise = strobe_sync[SYNC_STAGES-1] & ~strobe_q;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      tx_busy  <= 1'b0;
      bit_cnt  <= '0;
      link_out <= 1'b0;
    end else begin
      if (reply_valid && !tx_busy) begin
        tx_busy <= 1'b1;
        bit_cnt <= '0;
      end else if (tx_busy && strobe_rise) begin
        link_out <= shreg[0];
        if (bit_cnt == CNT_W'(FRAME_BITS)) begin
          tx_busy <= 1'b0;  // trailing 0 is on the line
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // zeros shift in from the top and form the trailing 0
  always_ff @(posedge sys_clk) begin
    if (reply_valid && !tx_busy) begin
      shreg <= {reply.byte1, reply.byte0, 1'b1};
    end else if (tx_busy && strobe_rise) begin
      shreg <= {1'b0, shreg[FRAME_BITS-1:1]};
    end
  end

endmodule

/* host_link_top.sv */
module host_link_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                    sys_clk,
  input  logic                    sys_rst_n,
  input  logic                    link_in,
  input  logic                    link_strobe,
  output logic                    link_out,
  output logic                    busy,
  output logic                    mem_req,
  output host_link_pkg::mem_req_t mem_cmd,
  input  logic                    mem_ack,
  input  host_link_pkg::word_t    mem_rdata
);

  logic                       frame_valid;
  host_link_pkg::link_frame_t frame;
  logic                       reply_valid;
  host_link_pkg::reply_t      reply;
  logic                       tx_busy;

  link_rx #(.SYNC_STAGES(SYNC_STAGES)) rx_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .link_in     (link_in),
    .link_strobe (link_strobe),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  cmd_exec exec_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .frame_valid (frame_valid),
    .frame       (frame),
    .tx_busy     (tx_busy),
    .reply_valid (reply_valid),
    .reply       (reply),
    .mem_req     (mem_req),
    .mem_cmd     (mem_cmd),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .busy        (busy)
  );

  link_tx #(.SYNC_STAGES(SYNC_STAGES)) tx_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .link_strobe (link_strobe),  // same host strobe drives the reply
    .reply_valid (reply_valid),
    .reply       (reply),
    .tx_busy     (tx_busy),
    .link_out    (link_out)
  );

endmodule

/* tb_checker.sv */
module tb_checker (
  input logic                    sys_clk,
  input logic                    link_strobe,
  input logic                    link_out,
  input logic                    busy,
  input logic                    mem_req,
  input host_link_pkg::mem_req_t mem_cmd
);

  timeunit 1ns;
  timeprecision 1ps;

  string                    test_name = "none";
  logic                     quiet = 1'b0;  // no DUT activity allowed
  logic                     exp_reply_on = 1'b0;
  host_link_pkg::word_t     exp_reply = '0;  // byte1:byte0
  logic                     exp_mem = 1'b0;
  logic                     exp_write = 1'b0;
  host_link_pkg::mem_addr_t exp_addr = '0;
  host_link_pkg::word_t     exp_wdata = '0;
  host_link_pkg::mem_req_t  req_seen = '0;
  logic                     req_q = 1'b0;
  logic                     got_reply = 1'b0;
  logic                     busy_seen = 1'b0;
  host_link_pkg::word_t     rx_word = '0;
  int                       rx_cnt = -1;  // -1 while waiting for a start bit
  int                       req_count = 0;
  int                       errors = 0;  // current test only
  int                       error_count = 0;
  int                       test_count = 0;
  int                       fail_count = 0;

  task automatic log_error(input string msg);
    $display("%s", msg);
    errors++;
    error_count++;
  endtask

  task automatic start_test(input string name, input logic idle_only, input logic reply_on,
                            input host_link_pkg::word_t reply, input logic mem_on,
                            input logic write, input host_link_pkg::mem_addr_t addr,
                            input host_link_pkg::word_t wdata);
    test_name    = name;
    quiet        = idle_only;
    exp_reply_on = reply_on;
    exp_reply    = reply;
    exp_mem      = mem_on;
    exp_write    = write;
    exp_addr     = addr;
    exp_wdata    = wdata;
    got_reply    = 1'b0;
    busy_seen    = 1'b0;
    req_count    = 0;
    errors       = 0;
  endtask

  // host side view of link_out, read on each strobe fall
  always @(negedge link_strobe) begin
    if (rx_cnt < 0) begin
      if (link_out) begin
        rx_cnt = 0;  // start bit
      end
    end else begin
      rx_word = {link_out, rx_word[15:1]};  // lsb arrives first
      rx_cnt++;
      if (rx_cnt == 16) begin
        rx_cnt    = -1;
        got_reply = 1'b1;
      end
    end
  end

  always @(posedge sys_clk) begin
    if (quiet && (busy || mem_req || link_out) && errors == 0) begin
      log_error($sformatf("%s: DUT became active with no frame sent", test_name));
    end
    if (busy) begin
      busy_seen = 1'b1;
    end
    if (mem_req && !req_q) begin
      req_count++;
      req_seen = mem_cmd;
      if (!exp_mem) begin
        log_error($sformatf("%s: memory request that was not expected", test_name));
      end else if (req_count > 1) begin
        log_error($sformatf("%s: more than one memory request", test_name));
      end
    end
    req_q = mem_req;
  end

  task automatic end_test(input host_link_pkg::word_t model_word);
    if (exp_reply_on && !got_reply) begin
      log_error($sformatf("%s: no reply frame came back", test_name));
    end else if (!exp_reply_on && got_reply) begin
      log_error($sformatf("%s: reply frame %h was not expected", test_name, rx_word));
    end else if (exp_reply_on && rx_word != exp_reply) begin
      log_error($sformatf("Mismatch %s reply: expected %h actual %h",
                          test_name, exp_reply, rx_word));
    end
    if (exp_mem && req_count == 0) begin
      log_error($sformatf("%s: no memory request was issued", test_name));
    end else if (exp_mem) begin
      if (req_seen.write != exp_write) begin
        log_error($sformatf("Mismatch %s write flag: expected %b actual %b",
                            test_name, exp_write, req_seen.write));
      end
      if (req_seen.addr != exp_addr) begin
        log_error($sformatf("Mismatch %s address: expected %h actual %h",
                            test_name, exp_addr, req_seen.addr));
      end
      if (exp_write && req_seen.wdata != exp_wdata) begin
        log_error($sformatf("Mismatch %s write data: expected %h actual %h",
                            test_name, exp_wdata, req_seen.wdata));
      end
      if (exp_write && model_word != exp_wdata) begin
        log_error($sformatf("Mismatch %s stored word: expected %h actual %h",
                            test_name, exp_wdata, model_word));
      end
    end
    if (!quiet && !busy_seen) begin
      log_error($sformatf("%s: busy never went high for the command", test_name));
    end
    test_count++;
    if (errors != 0) begin
      fail_count++;
    end
    $display("test %-14s %s", test_name, (errors == 0) ? "ok" : "failed");
    quiet = 1'b0;
  endtask

  task automatic print_summary();
    $display("%0d tests run, %0d failed, %0d errors", test_count, fail_count, error_count);
  endtask

endmodule

/* tb_host_link.sv */
module tb_host_link;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SYNC_STAGES   = 2;
  localparam int STROBE_HALF   = 4;    // sys_clk cycles per strobe phase
  localparam int REPLY_PERIODS = 20;   // strobes after a frame to clock a reply out
  localparam int TEST_CYCLES   = 400;  // run budget per table entry

  typedef struct {
    string                    name;
    host_link_pkg::byte_t     cmd;
    host_link_pkg::byte_t     arg;
    logic                     reply_on;
    host_link_pkg::word_t     reply;  // byte1:byte0
    logic                     mem_on;
    logic                     mem_write;
    host_link_pkg::mem_addr_t addr;
    host_link_pkg::word_t     wdata;
  } test_t;

  logic                    sys_clk;
  logic                    sys_rst_n;
  logic                    link_in;
  logic                    link_strobe;
  logic                    link_out;
  logic                    busy;
  logic                    mem_req;
  host_link_pkg::mem_req_t mem_cmd;
  logic                    mem_ack;
  host_link_pkg::word_t    mem_rdata;

  test_t                tests[$];
  host_link_pkg::byte_t regs_model [5] = '{default: '0};  // data0 data1 addr0 addr1 addr2
  host_link_pkg::word_t mem_expect [256] = '{default: '0};
  host_link_pkg::word_t mem_model [256] = '{default: '0};
  integer               seed = 42709;
  int                   cycle_cnt = 0;

  host_link_top #(.SYNC_STAGES(SYNC_STAGES)) dut_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .link_in     (link_in),
    .link_strobe (link_strobe),
    .link_out    (link_out),
    .busy        (busy),
    .mem_req     (mem_req),
    .mem_cmd     (mem_cmd),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata)
  );

  tb_checker chk_i (
    .sys_clk     (sys_clk),
    .link_strobe (link_strobe),
    .link_out    (link_out),
    .busy        (busy),
    .mem_req     (mem_req),
    .mem_cmd     (mem_cmd)
  );

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  // expected results follow from the command rules, tracked as the table grows
  task automatic add_test(input string name, input host_link_pkg::byte_t cmd,
                          input host_link_pkg::byte_t arg);
    test_t t;
    t.name      = name;
    t.cmd       = cmd;
    t.arg       = arg;
    t.reply_on  = 1'b0;
    t.reply     = '0;
    t.mem_on    = 1'b0;
    t.mem_write = 1'b0;
    t.addr      = {regs_model[4], regs_model[3], regs_model[2]};
    t.wdata     = {regs_model[1], regs_model[0]};
    case (cmd)
      8'h10, 8'h11, 8'h12, 8'h13, 8'h14: regs_model[cmd[2:0]] = arg;
      8'h30: begin
        t.reply_on = 1'b1;
        t.reply    = {arg, 8'h12};  // tag byte goes first
      end
      8'hA0: begin
        t.mem_on    = 1'b1;
        t.mem_write = 1'b1;
        mem_expect[t.addr[7:0]] = t.wdata;
      end
      8'hA1: begin
        t.mem_on   = 1'b1;
        t.reply_on = 1'b1;
        t.reply    = mem_expect[t.addr[7:0]];
      end
      default: ;  // no reply and no request
    endcase
    tests.push_back(t);
  endtask

  // one strobe period, data set up during the low phase
  task automatic strobe_bit(input logic value);
    link_in     = value;
    link_strobe = 1'b0;
    repeat (STROBE_HALF) @(negedge sys_clk);
    link_strobe = 1'b1;
    repeat (STROBE_HALF) @(negedge sys_clk);
  endtask

  task automatic send_frame(input host_link_pkg::byte_t cmd, input host_link_pkg::byte_t arg);
    logic [16:0] bits;
    int          b;
    bits = {arg, cmd, 1'b1};  // start bit, then cmd and arg lsb first
    for (b = 0; b < 17; b++) begin
      strobe_bit(bits[b]);
    end
  endtask

  task automatic run_test(input test_t t);
    int p;
    chk_i.start_test(t.name, 1'b0, t.reply_on, t.reply, t.mem_on, t.mem_write,
                     t.addr, t.wdata);
    send_frame(t.cmd, t.arg);
    for (p = 0; p < REPLY_PERIODS; p++) begin
      strobe_bit(1'b0);
    end
    link_strobe = 1'b0;  // last fall lets the host read the final bit
    repeat (STROBE_HALF) @(negedge sys_clk);
    while (busy) begin
      @(negedge sys_clk);
    end
    chk_i.end_test(mem_model[t.addr[7:0]]);
  endtask

  // four-phase handshake, answered after 1 to 6 cycles
  initial begin : memory
    int delay;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever begin
      @(negedge sys_clk);
      if (mem_req && !mem_ack) begin
        delay = 1 + int'($unsigned($random(seed)) % 6);
        repeat (delay) @(negedge sys_clk);
        if (mem_cmd.write) begin
          mem_model[mem_cmd.addr[7:0]] = mem_cmd.wdata;
        end
        mem_rdata = mem_model[mem_cmd.addr[7:0]];
        mem_ack   = 1'b1;
        while (mem_req) begin
          @(negedge sys_clk);
        end
        mem_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    @(posedge sys_clk);  // table is complete by now
    while (cycle_cnt < TEST_CYCLES * tests.size()) begin
      @(posedge sys_clk);
      cycle_cnt++;
    end
    $display("timeout: run did not end within %0d cycles", cycle_cnt);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    sys_rst_n   = 1'b0;
    link_in     = 1'b0;
    link_strobe = 1'b0;
    add_test("echo_a5", 8'h30, 8'hA5);
    add_test("set_data0", 8'h10, 8'h34);
    add_test("set_data1", 8'h11, 8'h12);
    add_test("set_addr0", 8'h12, 8'h56);
    add_test("set_addr1", 8'h13, 8'h02);
    add_test("set_addr2", 8'h14, 8'h03);
    add_test("write_1234", 8'hA0, 8'h00);
    add_test("read_1234", 8'hA1, 8'h00);
    add_test("set_data0_b", 8'h10, 8'hCD);
    add_test("set_data1_b", 8'h11, 8'hAB);
    add_test("set_addr0_b", 8'h12, 8'h80);
    add_test("write_abcd", 8'hA0, 8'h00);
    add_test("addr0_back", 8'h12, 8'h56);
    add_test("read_back", 8'hA1, 8'h00);
    add_test("addr0_fresh", 8'h12, 8'h57);
    add_test("read_blank", 8'hA1, 8'h00);
    add_test("unknown_55", 8'h55, 8'h00);
    add_test("echo_3c", 8'h30, 8'h3C);
    repeat (8) @(negedge sys_clk);
    sys_rst_n = 1'b1;
    chk_i.start_test("reset_idle", 1'b1, 1'b0, '0, 1'b0, 1'b0, '0, '0);
    repeat (40) @(negedge sys_clk);
    chk_i.end_test('0);
    foreach (tests[i]) begin
      run_test(tests[i]);
    end
    chk_i.print_summary();
    if (chk_i.error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
host_link_pkg.sv
link_rx.sv
cmd_exec.sv
link_tx.sv
host_link_top.sv
tb_checker.sv
tb_host_link.sv

/* run_sim.sh */
#!/bin/sh
# build and run the host link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_host_link -f verilog.f -o tb_host_link_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_host_link_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1
